//--- flist.f
+incdir+.
fp_decode_pkg.sv
fp_field_split.sv
fp_legal_check.sv
fp_ctrl_gen.sv
fp_decode_top.sv
fp_decode_asserts.sv
tb_fp_decode.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decoder testbench, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_fp_decode > sim.log 2>&1 \
  && ./obj_dir/Vtb_fp_decode >> sim.log 2>&1 \
  || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

//--- tb_fp_decode.sv
`timescale 1ns/1ps
`include "fp_decode_macros.svh"

module tb_fp_decode;

  localparam int N_DIR_WORDS  = 64;
  localparam int N_RAND_SLOTS = 240;
  // every word slot, a drain of up to 8 cycles per test, and slack
  localparam int WATCHDOG_CYC = N_DIR_WORDS + N_RAND_SLOTS + 6 * 8 + 20;

  // opcodes for forced random words, OP-FP twice as likely
  localparam logic [6:0] OPC_LIST [8] = '{`FP_OPC_LOAD, `FP_OPC_STORE, `FP_OPC_MADD,
    `FP_OPC_MSUB, `FP_OPC_NMSUB, `FP_OPC_NMADD, `FP_OPC_OP, `FP_OPC_OP};
  // listed selectors plus int conversions, moves and holes
  localparam logic [4:0] F5_LIST [16] = '{`FP_F5_ADD, `FP_F5_SUB, `FP_F5_MUL, `FP_F5_DIV,
    `FP_F5_SQRT, `FP_F5_SGNJ, `FP_F5_MINMAX, `FP_F5_CVTFF, `FP_F5_CMP, `FP_F5_CLASS,
    5'b11000, 5'b11010, 5'b11110, 5'b10000, 5'b01111, 5'b00110};

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    instr_valid_i;
  logic [`FP_INSTR_W-1:0]  instr_i;
  fp_decode_pkg::fp_ctrl_t dec_o;

  // expected results, the test that sent each and its due cycle, oldest first
  fp_decode_pkg::fp_ctrl_t exp_q[$];
  string                   name_q[$];
  int                      due_q[$];
  string                   test_name;
  int                      cyc_cnt;

  fp_decode_top dut0 (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .dec_o         (dec_o)
  );

  bind fp_decode_top fp_decode_asserts u_asserts (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .dec_i    (dec_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // rising edges seen so far
  always @(posedge clk_i) begin
    cyc_cnt++;
  end

  ////////////////////////////////////////
  // failure and compare tasks
  ////////////////////////////////////////

  task automatic raise_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic compare_ctrl(input string name, input fp_decode_pkg::fp_ctrl_t exp,
                              input fp_decode_pkg::fp_ctrl_t act);
    if (exp !== act) begin
      raise_failure($sformatf("[ERROR] %s: ctrl expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_op(input string name, input fp_decode_pkg::fp_op_e exp,
                            input fp_decode_pkg::fp_op_e act);
    if (exp !== act) begin
      raise_failure($sformatf("[ERROR] %s: op expected %s, actual %s", name, exp.name(),
                              act.name()));
    end
  endtask

  task automatic compare_fmt(input string name, input fp_decode_pkg::fp_fmt_e exp,
                             input fp_decode_pkg::fp_fmt_e act);
    if (exp !== act) begin
      raise_failure($sformatf("[ERROR] %s: fmt expected %s, actual %s", name, exp.name(),
                              act.name()));
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic fp_decode_pkg::fp_ctrl_t ref_decode(input logic [31:0] w);
    fp_decode_pkg::fp_ctrl_t c;
    logic [6:0]              opc;
    logic [2:0]              rm;
    logic                    dbl;
    logic                    bad;
    logic                    rsv;
    c            = '0;
    opc          = w[6:0];
    rm           = w[14:12];
    c.valid      = 1'b1;
    c.rm         = rm;
    c.rm_dynamic = (rm == 3'b111);
    c.raddr_a    = w[19:15];
    c.raddr_b    = w[24:20];
    c.raddr_c    = w[31:27];
    c.waddr      = w[11:7];
    // fmt2 bit 1 set means H or Q, bit 0 then picks D
    dbl          = w[25];
    bad          = w[26];
    rsv          = (rm == 3'b101) || (rm == 3'b110);
    if ((opc == `FP_OPC_LOAD) || (opc == `FP_OPC_STORE)) begin
      // funct3 gives the width
      bad         = (rm != 3'b010) && (rm != 3'b011);
      dbl         = (rm == 3'b011);
      c.data_req  = 1'b1;
      c.data_we   = (opc == `FP_OPC_STORE);
      c.fp_load   = (opc == `FP_OPC_LOAD);
      c.data_size = {1'b1, dbl};
    end else if ((opc == `FP_OPC_MADD) || (opc == `FP_OPC_MSUB)) begin
      bad      = bad | rsv;
      c.op_mod = (opc == `FP_OPC_MSUB);
    end else if ((opc == `FP_OPC_NMSUB) || (opc == `FP_OPC_NMADD)) begin
      bad      = bad | rsv;
      c.op     = fp_decode_pkg::FNMSUB;
      c.op_mod = (opc == `FP_OPC_NMADD);
    end else if (opc == `FP_OPC_OP) begin
      case (w[31:27])
        `FP_F5_ADD,
        `FP_F5_SUB: begin
          c.op     = fp_decode_pkg::ADD;
          c.op_mod = (w[31:27] == `FP_F5_SUB);
        end
        `FP_F5_MUL: c.op = fp_decode_pkg::MUL;
        `FP_F5_DIV: c.op = fp_decode_pkg::DIV;
        `FP_F5_SQRT: begin
          c.op = fp_decode_pkg::SQRT;
          bad  = bad | (w[24:20] != 5'd0);
        end
        `FP_F5_SGNJ: begin
          c.op = fp_decode_pkg::SGNJ;
          bad  = bad | (rm > 3'b010);
        end
        `FP_F5_MINMAX: begin
          c.op = fp_decode_pkg::MINMAX;
          bad  = bad | (rm > 3'b001);
        end
        `FP_F5_CMP: begin
          c.op    = fp_decode_pkg::CMP;
          c.rf_we = 1'b1;
          bad     = bad | (rm > 3'b010);
        end
        `FP_F5_CLASS: begin
          c.op    = fp_decode_pkg::CLASSIFY;
          c.rf_we = 1'b1;
          bad     = bad | (w[24:20] != 5'd0) | (rm != 3'b001);
        end
        `FP_F5_CVTFF: begin
          // rs2 names the source, 1 for D, 0 for S
          c.op = fp_decode_pkg::F2F;
          bad  = bad | (w[24:20] != {4'b0000, ~w[25]});
        end
        default: bad = 1'b1;
      endcase
      // operations that round reject the reserved codes
      if (c.op inside {fp_decode_pkg::ADD, fp_decode_pkg::MUL, fp_decode_pkg::DIV,
                       fp_decode_pkg::SQRT, fp_decode_pkg::F2F}) begin
        bad = bad | rsv;
      end
    end else begin
      bad = 1'b1;
    end
    c.dst_fmt = fp_decode_pkg::fp_fmt_e'(dbl);
    c.src_fmt = (c.op == fp_decode_pkg::F2F) ? fp_decode_pkg::fp_fmt_e'(~dbl) : c.dst_fmt;
    if (bad) begin
      c.illegal  = 1'b1;
      c.data_req = 1'b0;
      c.data_we  = 1'b0;
      c.fp_load  = 1'b0;
      c.rf_we    = 1'b0;
    end
    return c;
  endfunction

  // operator, formats and size carry no meaning on an illegal word
  function automatic fp_decode_pkg::fp_ctrl_t hide_unused(input fp_decode_pkg::fp_ctrl_t c,
                                                          input logic drop);
    fp_decode_pkg::fp_ctrl_t m;
    m = c;
    if (drop) begin
      m.op        = fp_decode_pkg::FMADD;
      m.op_mod    = 1'b0;
      m.src_fmt   = fp_decode_pkg::FP32;
      m.dst_fmt   = fp_decode_pkg::FP32;
      m.data_size = 2'b00;
    end
    return m;
  endfunction

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  // R4 layout, loads and stores reuse it with imm bits in the slots
  function automatic logic [31:0] pack_word(input logic [4:0] hi5, input logic [1:0] fmt2,
                                            input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {hi5, fmt2, rs2, rs1, f3, rd, opc};
  endfunction

  task automatic send_word(input logic [31:0] w);
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_i       = w;
    exp_q.push_back(ref_decode(w));
    name_q.push_back(test_name);
    // three rising edges after it is driven
    due_q.push_back(cyc_cnt + 3);
  endtask

  // bubble with garbage on the data lines
  task automatic send_gap(input logic [31:0] w);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    instr_i       = w;
  endtask

  task automatic drain();
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic run_load_store();
    logic [2:0] f3;
    int         k;
    test_name = "load_store";
    for (k = 2; k <= 4; k++) begin
      // k = 4 stands for funct3 000, no such width
      f3 = (k == 4) ? 3'b000 : k[2:0];
      send_word(pack_word(5'd1, 2'd0, 5'd9, 5'd7, f3, 5'd3, `FP_OPC_LOAD));
      send_word(pack_word(5'd0, 2'd1, 5'd14, 5'd5, f3, 5'd4, `FP_OPC_STORE));
    end
    drain();
  endtask

  task automatic run_fma_arith();
    logic [6:0] opc [4];
    logic [4:0] f5 [5];
    int         f;
    int         k;
    opc[0] = `FP_OPC_MADD;
    opc[1] = `FP_OPC_MSUB;
    opc[2] = `FP_OPC_NMSUB;
    opc[3] = `FP_OPC_NMADD;
    f5[0]  = `FP_F5_ADD;
    f5[1]  = `FP_F5_SUB;
    f5[2]  = `FP_F5_MUL;
    f5[3]  = `FP_F5_DIV;
    f5[4]  = `FP_F5_SQRT;
    test_name = "fma_arith";
    for (f = 0; f < 2; f++) begin
      for (k = 0; k < 4; k++) begin
        send_word(pack_word(5'd11, f[1:0], 5'd12, 5'd13, 3'b000, 5'd14, opc[k]));
      end
      for (k = 0; k < 5; k++) begin
        // sqrt keeps rs2 at zero
        send_word(pack_word(f5[k], f[1:0], (k == 4) ? 5'd0 : 5'd6, 5'd2, 3'b001, 5'd8,
                            `FP_OPC_OP));
      end
    end
    // dynamic rounding, a reserved code, sqrt with rs2 set
    send_word(pack_word(`FP_F5_MUL, 2'd1, 5'd3, 5'd4, `FP_RM_DYN, 5'd5, `FP_OPC_OP));
    send_word(pack_word(`FP_F5_ADD, 2'd0, 5'd3, 5'd4, `FP_RM_RSV0, 5'd5, `FP_OPC_OP));
    send_word(pack_word(`FP_F5_SQRT, 2'd0, 5'd3, 5'd4, 3'b000, 5'd5, `FP_OPC_OP));
    drain();
  endtask

  task automatic run_sgnj_cmp_class();
    int f;
    int k;
    test_name = "sgnj_cmp_class";
    for (f = 0; f < 2; f++) begin
      // rm 011 is one past the last variant
      for (k = 0; k < 4; k++) begin
        send_word(pack_word(`FP_F5_SGNJ, f[1:0], 5'd1, 5'd2, k[2:0], 5'd3, `FP_OPC_OP));
        send_word(pack_word(`FP_F5_CMP, f[1:0], 5'd1, 5'd2, k[2:0], 5'd3, `FP_OPC_OP));
      end
      for (k = 0; k < 3; k++) begin
        send_word(pack_word(`FP_F5_MINMAX, f[1:0], 5'd1, 5'd2, k[2:0], 5'd3, `FP_OPC_OP));
      end
      // FCLASS only with funct3 001
      send_word(pack_word(`FP_F5_CLASS, f[1:0], 5'd0, 5'd2, 3'b000, 5'd3, `FP_OPC_OP));
      send_word(pack_word(`FP_F5_CLASS, f[1:0], 5'd0, 5'd2, 3'b001, 5'd3, `FP_OPC_OP));
    end
    send_word(pack_word(`FP_F5_CLASS, 2'd0, 5'd4, 5'd2, 3'b001, 5'd3, `FP_OPC_OP));
    drain();
  endtask

  task automatic run_cvt();
    int f;
    int k;
    test_name = "cvt_ff";
    // one rs2 value per fmt2 is legal
    for (f = 0; f < 2; f++) begin
      for (k = 0; k < 2; k++) begin
        send_word(pack_word(`FP_F5_CVTFF, f[1:0], k[4:0], 5'd9, 3'b000, 5'd10, `FP_OPC_OP));
      end
    end
    drain();
  endtask

  task automatic run_random();
    logic [31:0] r;
    logic [31:0] w;
    int          n;
    test_name = "random";
    for (n = 0; n < N_RAND_SLOTS; n++) begin
      r = $urandom();
      w = $urandom();
      // about half the words land on FP opcodes
      if (r[2]) begin
        w[6:0] = OPC_LIST[r[5:3]];
        if (r[6]) begin
          w[26:25] = {1'b0, r[7]};
        end
        if (r[8]) begin
          w[31:27] = F5_LIST[r[12:9]];
        end
      end
      if (r[1:0] == 2'b00) begin
        send_gap(w);
      end else begin
        send_word(w);
      end
    end
    drain();
  endtask

  task automatic run_reset();
    int k;
    test_name = "reset";
    // this one is lost to the reset
    send_word(pack_word(`FP_F5_ADD, 2'd0, 5'd1, 5'd2, 3'b000, 5'd3, `FP_OPC_OP));
    @(negedge clk_i);
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    exp_q.delete();
    name_q.delete();
    due_q.delete();
    for (k = 0; k < 2; k++) begin
      #1;
      compare_ctrl(test_name, '0, dec_o);
      @(negedge clk_i);
    end
    arst_n_i = 1'b1;
    send_word(pack_word(`FP_F5_MUL, 2'd1, 5'd4, 5'd5, 3'b001, 5'd6, `FP_OPC_OP));
    send_word(pack_word(`FP_F5_CLASS, 2'd0, 5'd0, 5'd5, 3'b001, 5'd7, `FP_OPC_OP));
    drain();
  endtask

  ////////////////////////////////////////
  // monitor, main sequence, watchdog
  ////////////////////////////////////////

  // outputs settle after the rising edge, read them on the falling one
  initial begin
    fp_decode_pkg::fp_ctrl_t exp;
    string                   name;
    forever begin
      @(negedge clk_i);
      if (arst_n_i) begin
        if ((due_q.size() != 0) && (due_q[0] == cyc_cnt)) begin
          if (!dec_o.valid) begin
            raise_failure($sformatf("%s: no result three cycles after the word went in",
                                    name_q[0]));
          end else begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            due_q.delete(0);
            if (!exp.illegal) begin
              compare_op(name, exp.op, dec_o.op);
              compare_fmt(name, exp.src_fmt, dec_o.src_fmt);
              compare_fmt(name, exp.dst_fmt, dec_o.dst_fmt);
            end
            compare_ctrl(name, hide_unused(exp, exp.illegal),
                         hide_unused(dec_o, exp.illegal));
          end
        end else if (dec_o.valid) begin
          raise_failure("a result came out with no word due in that cycle");
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h2f17_15ba));
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    cyc_cnt       = 0;
    test_name     = "init";
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    run_load_store();
    run_fma_arith();
    run_sgnj_cmp_class();
    run_cvt();
    run_random();
    run_reset();
    // quiet tail, a stray result still reaches the monitor
    repeat (4) @(negedge clk_i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * 100);
    raise_failure("timeout, the decoder stopped returning results");
  end

endmodule

//--- fp_decode_asserts.sv
`timescale 1ns/1ps
`include "fp_decode_macros.svh"

module fp_decode_asserts (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input fp_decode_pkg::fp_ctrl_t dec_i
);

  logic side_fx;

  // anything that leaves the decoder toward LSU or int file
  assign side_fx = dec_i.data_req | dec_i.data_we | dec_i.fp_load | dec_i.rf_we;

  ////////////////////////////////////////
  // squash rules
  ////////////////////////////////////////

  // illegal words stay away from memory and the int file
  illegal_quiet: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) dec_i.illegal |-> !side_fx
  ) else $error("illegal word carries a request or a write enable");

  // bubbles carry no controls
  bubble_quiet: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !dec_i.valid |-> !side_fx
  ) else $error("bubble carries a request or a write enable");

  ////////////////////////////////////////
  // field consistency
  ////////////////////////////////////////

  // a store is always a request
  we_needs_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) dec_i.data_we |-> dec_i.data_req
  ) else $error("data_we high without data_req");

  rm_dyn_flag: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) dec_i.rm_dynamic == (dec_i.rm == `FP_RM_DYN)
  ) else $error("rm_dynamic disagrees with rm");

endmodule

//--- fp_decode_top.sv
`timescale 1ns/1ps
`include "fp_decode_macros.svh"

module fp_decode_top #(
  parameter fp_decode_pkg::rvf_e RVF = fp_decode_pkg::RVF_DOUBLE
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      instr_valid_i,
  input  logic [`FP_INSTR_W-1:0]    instr_i,
  output fp_decode_pkg::fp_ctrl_t   dec_o
);

  ////////////////////////////////////////
  // inter-stage wires
  ////////////////////////////////////////

  // stage 1 to stage 2
  fp_decode_pkg::fp_fields_t fields;
  // stage 2 to stage 3
  fp_decode_pkg::fp_class_t  cls;

  ////////////////////////////////////////
  // pipeline
  ////////////////////////////////////////

  // stage 1, register and slice
  fp_field_split u_split (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .fields_o      (fields)
  );

  // stage 2, class, formats, legality
  fp_legal_check #(
    .RVF (RVF)
  ) u_legal (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .fields_i (fields),
    .class_o  (cls)
  );

  // stage 3, operator and side-effect controls
  fp_ctrl_gen u_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .class_i  (cls),
    .ctrl_o   (dec_o)
  );

endmodule

//--- fp_ctrl_gen.sv
`timescale 1ns/1ps
`include "fp_decode_macros.svh"

module fp_ctrl_gen (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  fp_decode_pkg::fp_class_t  class_i,
  output fp_decode_pkg::fp_ctrl_t   ctrl_o
);

  fp_decode_pkg::fp_fields_t fld;
  fp_decode_pkg::fp_op_e     op;
  fp_decode_pkg::fp_ctrl_t   ctrl_d;
  logic                      op_mod;
  logic                      is_load;
  logic                      is_store;
  logic                      is_int_wb;
  logic                      kill;

  assign fld = class_i.fields;

  ////////////////////////////////////////
  // operator map
  ////////////////////////////////////////

  always_comb begin
    op     = fp_decode_pkg::FMADD;
    op_mod = 1'b0;
    case (class_i.instr_class)
      fp_decode_pkg::CL_FMA: begin
        // madd/msub share FMADD, nmsub/nmadd share FNMSUB
        if ((fld.opcode == `FP_OPC_MADD) || (fld.opcode == `FP_OPC_MSUB)) begin
          op = fp_decode_pkg::FMADD;
        end else begin
          op = fp_decode_pkg::FNMSUB;
        end
        // modifier flips the addend sign
        op_mod = (fld.opcode == `FP_OPC_MSUB) || (fld.opcode == `FP_OPC_NMADD);
      end
      fp_decode_pkg::CL_ARITH: begin
        case (fld.funct5)
          `FP_F5_MUL: op = fp_decode_pkg::MUL;
          `FP_F5_DIV: op = fp_decode_pkg::DIV;
          // add and sub
          default:    op = fp_decode_pkg::ADD;
        endcase
        op_mod = (fld.funct5 == `FP_F5_SUB);
      end
      fp_decode_pkg::CL_SQRT:   op = fp_decode_pkg::SQRT;
      fp_decode_pkg::CL_SGNJ:   op = fp_decode_pkg::SGNJ;
      fp_decode_pkg::CL_MINMAX: op = fp_decode_pkg::MINMAX;
      fp_decode_pkg::CL_CVTFF:  op = fp_decode_pkg::F2F;
      fp_decode_pkg::CL_CMP:    op = fp_decode_pkg::CMP;
      fp_decode_pkg::CL_CLASS:  op = fp_decode_pkg::CLASSIFY;
      // loads, stores and unknown words keep the default
      default: op = fp_decode_pkg::FMADD;
    endcase
  end

  ////////////////////////////////////////
  // LSU and write-back
  ////////////////////////////////////////

  assign is_load   = (class_i.instr_class == fp_decode_pkg::CL_LOAD);
  assign is_store  = (class_i.instr_class == fp_decode_pkg::CL_STORE);
  // results that land in the integer file
  assign is_int_wb = (class_i.instr_class == fp_decode_pkg::CL_CMP) ||
                     (class_i.instr_class == fp_decode_pkg::CL_CLASS);
  // squash for bubbles and illegal words
  assign kill      = ~fld.valid | class_i.illegal;

  always_comb begin
    ctrl_d.valid      = fld.valid;
    ctrl_d.illegal    = class_i.illegal;
    ctrl_d.op         = op;
    ctrl_d.op_mod     = op_mod;
    ctrl_d.src_fmt    = class_i.src_fmt;
    ctrl_d.dst_fmt    = class_i.dst_fmt;
    ctrl_d.rm         = fld.rm;
    ctrl_d.rm_dynamic = (fld.rm == `FP_RM_DYN);
    // operand and destination indices
    ctrl_d.raddr_a    = fld.rs1;
    ctrl_d.raddr_b    = fld.rs2;
    ctrl_d.raddr_c    = fld.rs3;
    ctrl_d.waddr      = fld.rd;
    ctrl_d.data_req   = (is_load | is_store) & ~kill;
    ctrl_d.data_we    = is_store & ~kill;
    ctrl_d.fp_load    = is_load & ~kill;
    // 10 word, 11 double
    ctrl_d.data_size  = (is_load | is_store) ?
                        {1'b1, class_i.src_fmt == fp_decode_pkg::FP64} : 2'b00;
    ctrl_d.rf_we      = is_int_wb & ~kill;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_d;
    end
  end

endmodule

//--- fp_legal_check.sv
`timescale 1ns/1ps
`include "fp_decode_macros.svh"

module fp_legal_check #(
  parameter fp_decode_pkg::rvf_e RVF = fp_decode_pkg::RVF_DOUBLE
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  fp_decode_pkg::fp_fields_t  fields_i,
  output fp_decode_pkg::fp_class_t   class_o
);

  fp_decode_pkg::fp_class_e cls;
  fp_decode_pkg::fp_fmt_e   fmt_ls;
  fp_decode_pkg::fp_fmt_e   fmt_op;
  fp_decode_pkg::fp_fmt_e   src_fmt;
  fp_decode_pkg::fp_fmt_e   dst_fmt;
  fp_decode_pkg::fp_class_t class_d;
  logic                     ls_fmt_bad;
  logic                     op_fmt_bad;
  logic                     rm_rsv;
  logic                     rs2_zero;
  logic                     needs_double;
  logic                     illegal_raw;

  // load/store width from funct3, only W and D exist
  assign ls_fmt_bad = (fields_i.rm != 3'b010) && (fields_i.rm != 3'b011);
  assign fmt_ls     = (fields_i.rm == 3'b011) ? fp_decode_pkg::FP64 : fp_decode_pkg::FP32;

  // fmt2 10 (half) and 11 (quad) not supported
  assign op_fmt_bad = fields_i.fmt2[1];
  assign fmt_op     = (fields_i.fmt2 == 2'b01) ? fp_decode_pkg::FP64 : fp_decode_pkg::FP32;

  // reserved rounding codes
  assign rm_rsv   = (fields_i.rm == `FP_RM_RSV0) || (fields_i.rm == `FP_RM_RSV1);
  assign rs2_zero = (fields_i.rs2 == '0);

  ////////////////////////////////////////
  // classification
  ////////////////////////////////////////

  always_comb begin
    cls = fp_decode_pkg::CL_NONE;
    case (fields_i.opcode)
      `FP_OPC_LOAD:  cls = fp_decode_pkg::CL_LOAD;
      `FP_OPC_STORE: cls = fp_decode_pkg::CL_STORE;
      `FP_OPC_MADD,
      `FP_OPC_MSUB,
      `FP_OPC_NMSUB,
      `FP_OPC_NMADD: cls = fp_decode_pkg::CL_FMA;
      `FP_OPC_OP: begin
        case (fields_i.funct5)
          `FP_F5_ADD,
          `FP_F5_SUB,
          `FP_F5_MUL,
          `FP_F5_DIV:    cls = fp_decode_pkg::CL_ARITH;
          `FP_F5_SQRT:   cls = fp_decode_pkg::CL_SQRT;
          `FP_F5_SGNJ:   cls = fp_decode_pkg::CL_SGNJ;
          `FP_F5_MINMAX: cls = fp_decode_pkg::CL_MINMAX;
          `FP_F5_CVTFF:  cls = fp_decode_pkg::CL_CVTFF;
          `FP_F5_CMP:    cls = fp_decode_pkg::CL_CMP;
          `FP_F5_CLASS:  cls = fp_decode_pkg::CL_CLASS;
          // unlisted funct5, incl. int conversions and moves
          default:       cls = fp_decode_pkg::CL_NONE;
        endcase
      end
      default: cls = fp_decode_pkg::CL_NONE;
    endcase
  end

  ////////////////////////////////////////
  // formats and legality
  ////////////////////////////////////////

  always_comb begin
    src_fmt     = fmt_op;
    dst_fmt     = fmt_op;
    illegal_raw = 1'b0;
    case (cls)
      fp_decode_pkg::CL_LOAD,
      fp_decode_pkg::CL_STORE: begin
        src_fmt     = fmt_ls;
        dst_fmt     = fmt_ls;
        illegal_raw = ls_fmt_bad;
      end
      fp_decode_pkg::CL_FMA,
      fp_decode_pkg::CL_ARITH: illegal_raw = op_fmt_bad | rm_rsv;
      // unary, rs2 slot must be zero
      fp_decode_pkg::CL_SQRT:   illegal_raw = op_fmt_bad | rm_rsv | ~rs2_zero;
      // rm picks J / JN / JX
      fp_decode_pkg::CL_SGNJ:   illegal_raw = op_fmt_bad | (fields_i.rm > 3'b010);
      // rm picks MIN / MAX
      fp_decode_pkg::CL_MINMAX: illegal_raw = op_fmt_bad | (fields_i.rm > 3'b001);
      // rm picks LE / LT / EQ
      fp_decode_pkg::CL_CMP:    illegal_raw = op_fmt_bad | (fields_i.rm > 3'b010);
      fp_decode_pkg::CL_CLASS: begin
        illegal_raw = op_fmt_bad | ~rs2_zero | (fields_i.rm != 3'b001);
      end
      fp_decode_pkg::CL_CVTFF: begin
        // dst is fmt2, source is the other width
        src_fmt = (fmt_op == fp_decode_pkg::FP64) ? fp_decode_pkg::FP32 :
                                                    fp_decode_pkg::FP64;
        // rs2 encodes the source format
        illegal_raw = op_fmt_bad | rm_rsv |
                      (fields_i.rs2 != ((fmt_op == fp_decode_pkg::FP32) ? 5'd1 : 5'd0));
      end
      // not an FP opcode or unknown funct5
      default: illegal_raw = 1'b1;
    endcase

    // double needs D support, anything needs F
    needs_double = (src_fmt == fp_decode_pkg::FP64) || (dst_fmt == fp_decode_pkg::FP64);
    if (needs_double && (RVF != fp_decode_pkg::RVF_DOUBLE)) begin
      illegal_raw = 1'b1;
    end
    if (RVF == fp_decode_pkg::RVF_NONE) begin
      illegal_raw = 1'b1;
    end
  end

  always_comb begin
    class_d.fields      = fields_i;
    class_d.instr_class = cls;
    class_d.src_fmt     = src_fmt;
    class_d.dst_fmt     = dst_fmt;
    // bubbles never flag illegal
    class_d.illegal     = fields_i.valid & illegal_raw;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      class_o <= '0;
    end else begin
      class_o <= class_d;
    end
  end

endmodule

//--- fp_field_split.sv
`timescale 1ns/1ps
`include "fp_decode_macros.svh"

module fp_field_split (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       instr_valid_i,
  input  logic [`FP_INSTR_W-1:0]     instr_i,
  output fp_decode_pkg::fp_fields_t  fields_o
);

  fp_decode_pkg::fp_fields_t fields_d;

  ////////////////////////////////////////
  // field slicing
  ////////////////////////////////////////

  always_comb begin
    fields_d.valid  = instr_valid_i;
    fields_d.opcode = instr_i[6:0];
    // destination
    fields_d.rd     = instr_i[11:7];
    // funct3 slot, rounding mode for arithmetic
    fields_d.rm     = instr_i[14:12];
    // sources
    fields_d.rs1    = instr_i[19:15];
    fields_d.rs2    = instr_i[24:20];
    fields_d.rs3    = instr_i[31:27];
    // format bits of OP-FP and FMA words
    fields_d.fmt2   = instr_i[26:25];
    // same bits as rs3, read as an OP-FP selector
    fields_d.funct5 = instr_i[31:27];
  end

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  // whole word cleared on reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fields_o <= '0;
    end else begin
      fields_o <= fields_d;
    end
  end

endmodule

//--- fp_decode_pkg.sv
`include "fp_decode_macros.svh"

package fp_decode_pkg;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // which FP extensions the core carries
  typedef enum logic [1:0] {
    RVF_NONE   = 2'd0,
    RVF_SINGLE = 2'd1,
    RVF_DOUBLE = 2'd2
  } rvf_e;

  typedef enum logic {
    FP32 = 1'b0,
    FP64 = 1'b1
  } fp_fmt_e;

  // operator handed to the FPU
  typedef enum logic [3:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL,
    DIV,
    SQRT,
    SGNJ,
    MINMAX,
    CMP,
    F2F,
    CLASSIFY
  } fp_op_e;

  // coarse instruction class found in stage 2
  typedef enum logic [3:0] {
    CL_NONE,
    CL_LOAD,
    CL_STORE,
    CL_FMA,
    CL_ARITH,
    CL_SQRT,
    CL_SGNJ,
    CL_MINMAX,
    CL_CVTFF,
    CL_CMP,
    CL_CLASS
  } fp_class_e;

  ////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////

  // stage 1 output, raw fields of the word
  typedef struct packed {
    logic                   valid;
    logic [`FP_OPC_W-1:0]   opcode;
    logic [`FP_RADDR_W-1:0] rd;
    logic [`FP_RADDR_W-1:0] rs1;
    logic [`FP_RADDR_W-1:0] rs2;
    logic [`FP_RADDR_W-1:0] rs3;
    // also funct3 for loads and stores
    logic [`FP_RM_W-1:0]    rm;
    logic [1:0]             fmt2;
    logic [`FP_F5_W-1:0]    funct5;
  } fp_fields_t;

  // stage 2 output
  typedef struct packed {
    fp_fields_t fields;
    fp_class_e  instr_class;
    fp_fmt_e    src_fmt;
    fp_fmt_e    dst_fmt;
    logic       illegal;
  } fp_class_t;

  // final decoded controls
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    fp_op_e                 op;
    logic                   op_mod;
    fp_fmt_e                src_fmt;
    fp_fmt_e                dst_fmt;
    logic [`FP_RM_W-1:0]    rm;
    logic                   rm_dynamic;
    logic [`FP_RADDR_W-1:0] raddr_a;
    logic [`FP_RADDR_W-1:0] raddr_b;
    logic [`FP_RADDR_W-1:0] raddr_c;
    logic [`FP_RADDR_W-1:0] waddr;
    logic                   data_req;
    logic                   data_we;
    logic [1:0]             data_size;
    logic                   fp_load;
    logic                   rf_we;
  } fp_ctrl_t;

endpackage

//--- fp_decode_macros.svh
`ifndef FP_DECODE_MACROS_SVH
`define FP_DECODE_MACROS_SVH

// field widths
`define FP_INSTR_W 32
`define FP_RADDR_W 5
`define FP_OPC_W   7
`define FP_RM_W    3
`define FP_F5_W    5

// major opcodes for the F and D extensions
`define FP_OPC_LOAD  7'b0000111
`define FP_OPC_STORE 7'b0100111
`define FP_OPC_MADD  7'b1000011
`define FP_OPC_MSUB  7'b1000111
`define FP_OPC_NMSUB 7'b1001011
`define FP_OPC_NMADD 7'b1001111
`define FP_OPC_OP    7'b1010011

// funct7[31:27] selectors inside OP-FP
`define FP_F5_ADD    5'b00000
`define FP_F5_SUB    5'b00001
`define FP_F5_MUL    5'b00010
`define FP_F5_DIV    5'b00011
`define FP_F5_SQRT   5'b01011
`define FP_F5_SGNJ   5'b00100
`define FP_F5_MINMAX 5'b00101
`define FP_F5_CVTFF  5'b01000
`define FP_F5_CMP    5'b10100
`define FP_F5_CLASS  5'b11100

// rounding codes
`define FP_RM_DYN  3'b111
`define FP_RM_RSV0 3'b101
`define FP_RM_RSV1 3'b110

`endif
